// File: files.f
+incdir+include
verilog/nx_pkg.sv
verilog/nx_instr_loader.sv
verilog/nx_instr_ram.sv
verilog/nx_node_core.sv
verilog/nx_node.sv
bench/nx_node_tb.sv

// File: Bender.yml
package:
  name: nx_node

sources:
  # Design, package first
  - include_dirs:
      - include
    files:
      - verilog/nx_pkg.sv
      - verilog/nx_instr_loader.sv
      - verilog/nx_instr_ram.sv
      - verilog/nx_node_core.sv
      - verilog/nx_node.sv
  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - bench/nx_node_tb.sv

// File: bench/nx_node_tb.sv
// Logic node testbench
`include "nx_config.svh"

module nx_node_tb
import nx_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int PROG_LEN  = 20;
localparam int SHORT_LEN = 6;
// Reset, loads, then four cycles per executed instruction plus margin
// Runs 1 to 4 execute the long program, run 5 the short one
localparam int TIMEOUT_CYCLES =
    10 + PROG_LEN + SHORT_LEN + 4 * (4 * PROG_LEN + SHORT_LEN) + 100;

logic i_clk, i_arst_n, i_load_valid, i_load_clear, i_trigger, i_stall;
logic [`NX_RAM_DATA_W-1:0] i_load_data;
logic [`NX_INPUTS-1:0]     i_inputs;
logic [`NX_OUTPUTS-1:0]    o_outputs;
logic                      o_idle;

// Reference model state, kept across runs like the node
instruction_t             prog[$];
logic [`NX_REGISTERS-1:0] model_regs;
logic [`NX_OUTPUTS-1:0]   model_out;
logic [`NX_INPUTS-1:0]    run_inputs;

// Check strobes and expected values
logic                   check_out, check_len, idle_high;
logic [`NX_OUTPUTS-1:0] exp_outputs;
int                     exp_len, busy_cnt, stall_cnt;
int                     mismatches, failures, cycle_cnt;

nx_node i_nx_node (
      .i_clk        ( i_clk        )
    , .i_arst_n     ( i_arst_n     )
    , .i_load_valid ( i_load_valid )
    , .i_load_data  ( i_load_data  )
    , .i_load_clear ( i_load_clear )
    , .i_inputs     ( i_inputs     )
    , .i_trigger    ( i_trigger    )
    , .i_stall      ( i_stall      )
    , .o_outputs    ( o_outputs    )
    , .o_idle       ( o_idle       )
);

always #2 i_clk = ~i_clk;

always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles waiting for o_idle", cycle_cnt);
        $display("TEST FAILED");
        $finish;
    end
end

// ==================================================
// Checks
// ==================================================

// Around reset and after an empty-program trigger
idle_stays_high: assert property (@(posedge i_clk) idle_high |-> o_idle)
    else begin
        mismatches++;
        $display("MISMATCH time=%0t signal=o_idle expected=1 actual=%b", $time, $sampled(o_idle));
    end

outputs_match: assert property (@(posedge i_clk) check_out |-> (o_outputs == exp_outputs))
    else begin
        mismatches++;
        $display("MISMATCH time=%0t signal=o_outputs expected=%h actual=%h",
                 $time, exp_outputs, $sampled(o_outputs));
    end

// Busy time is N+2 plus stalled cycles
run_length: assert property (@(posedge i_clk) check_len |-> (busy_cnt == exp_len))
    else begin
        failures++;
        $display("Run length wrong at %0t: o_idle low for %0d cycles, expected %0d",
                 $time, busy_cnt, exp_len);
    end

// ==================================================
// Reference model
// ==================================================

function automatic logic model_operand(input logic from_input, input logic [NX_IOR_W-1:0] idx);
    logic [3:0] reg_idx;
    reg_idx = idx[3:0];
    return from_input ? run_inputs[idx] : model_regs[reg_idx];
endfunction

// One pass over the stored program, output position from zero
task automatic model_run();
    logic [2:0] sel;
    int         out_pos;
    out_pos = 0;
    foreach (prog[k]) begin
        sel = {model_operand(prog[k].src_a_ip, prog[k].src_a),
               model_operand(prog[k].src_b_ip, prog[k].src_b),
               model_operand(prog[k].src_c_ip, prog[k].src_c)};
        model_regs[prog[k].tgt_reg] = prog[k].truth[sel];
        if (prog[k].gen_out) begin
            model_out[out_pos] = prog[k].truth[sel];
            out_pos++;
        end
    end
endtask

// ==================================================
// Stimulus
// ==================================================

// Random words appended after the current program
task automatic load_program(input int n);
    logic [31:0]  r;
    instruction_t w;
    repeat (n) begin
        r = $urandom;
        w = r[$bits(instruction_t)-1:0];
        prog.push_back(w);
        @(posedge i_clk);
        i_load_valid <= 1'b1;
        i_load_data  <= `NX_RAM_DATA_W'(w);
    end
    @(posedge i_clk);
    i_load_valid <= 1'b0;
endtask

task automatic clear_program();
    @(posedge i_clk);
    i_load_clear <= 1'b1;
    @(posedge i_clk);
    i_load_clear <= 1'b0;
    prog.delete();
endtask

// Trigger, then count busy cycles until o_idle rises again
// Optional random stall, a second trigger, and loads while busy
task automatic run_and_wait(input bit stalls, input int retrig_at, input int junk_cnt);
    bit done;
    done      = 1'b0;
    busy_cnt  = 0;
    stall_cnt = 0;
    @(posedge i_clk);
    run_inputs = $urandom;
    i_inputs  <= run_inputs;
    i_trigger <= 1'b1;
    while (!done) begin
        @(posedge i_clk);
        i_trigger    <= (retrig_at != 0) && (busy_cnt == retrig_at);
        i_stall      <= stalls && ($urandom_range(0, 1) == 1);
        // Stays well inside the run so o_idle is low when sampled
        i_load_valid <= (busy_cnt >= 1) && (busy_cnt <= junk_cnt);
        i_load_data  <= $urandom;
        @(negedge i_clk);
        if (!o_idle) begin
            busy_cnt++;
            // Stall seen by the next edge while busy
            if (i_stall) begin
                stall_cnt++;
            end
        end else if (busy_cnt != 0) begin
            done = 1'b1;
        end
    end
    @(posedge i_clk);
    i_stall      <= 1'b0;
    i_load_valid <= 1'b0;
endtask

// One-cycle strobe of the output and length checks
// Held trigger acts in the first cycle after the drain, one extra busy cycle
task automatic check_run(input bit with_len, input int runs);
    @(posedge i_clk);
    exp_outputs <= model_out;
    exp_len     <= runs * (prog.size() + 2) + (runs - 1) + stall_cnt;
    check_out   <= 1'b1;
    check_len   <= with_len;
    @(posedge i_clk);
    check_out <= 1'b0;
    check_len <= 1'b0;
endtask

// ==================================================
// Test sequence
// ==================================================

initial begin
    void'($urandom(32'h6ebc_672c));
    i_clk        = 1'b0;
    i_arst_n     <= 1'b0;
    i_load_valid <= 1'b0;
    i_load_data  <= '0;
    i_load_clear <= 1'b0;
    i_inputs     <= '0;
    i_trigger    <= 1'b0;
    i_stall      <= 1'b0;
    model_regs   = '0;
    model_out    = '0;
    mismatches   = 0;
    failures     = 0;
    cycle_cnt    = 0;
    busy_cnt     = 0;
    exp_len      = 0;
    check_len    <= 1'b0;
    // Idle and cleared outputs through reset
    idle_high    <= 1'b1;
    check_out    <= 1'b1;
    exp_outputs  <= '0;
    repeat (10) @(posedge i_clk);
    i_arst_n <= 1'b1;
    repeat (2) @(posedge i_clk);
    idle_high <= 1'b0;
    check_out <= 1'b0;

    // Plain run, with loads offered while busy
    load_program(PROG_LEN);
    run_and_wait(1'b0, 0, 4);
    model_run();
    check_run(1'b1, 1);

    // Same program under stall, length exposes any accepted busy load
    run_and_wait(1'b1, 0, 0);
    model_run();
    check_run(1'b1, 1);

    // Retrigger mid-run gives two runs back to back
    // o_idle stays low across both, so the length covers the pair
    run_and_wait(1'b0, 3, 0);
    model_run();
    model_run();
    check_run(1'b1, 2);

    // Shorter program after a clear
    clear_program();
    load_program(SHORT_LEN);
    run_and_wait(1'b0, 0, 0);
    model_run();
    check_run(1'b1, 1);

    // Empty program, trigger has no effect
    clear_program();
    @(posedge i_clk);
    idle_high <= 1'b1;
    i_trigger <= 1'b1;
    @(posedge i_clk);
    i_trigger <= 1'b0;
    repeat (8) @(posedge i_clk);
    idle_high <= 1'b0;
    check_run(1'b0, 0);

    repeat (2) @(posedge i_clk);
    $display("Checks done: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : nx_node_tb

// File: verilog/nx_node.sv
// Logic node top level
`include "nx_config.svh"

module nx_node
import nx_pkg::*;
(
      input  logic                      i_clk
    , input  logic                      i_arst_n
    // Program load
    , input  logic                      i_load_valid
    , input  logic [`NX_RAM_DATA_W-1:0] i_load_data
    , input  logic                      i_load_clear
    // Execution
    , input  logic [`NX_INPUTS-1:0]     i_inputs
    , input  logic                      i_trigger
    , input  logic                      i_stall
    , output logic [`NX_OUTPUTS-1:0]    o_outputs
    , output logic                      o_idle
);

// ==================================================
// Internal nets
// ==================================================

// Loader to RAM
logic                      wr_en;
logic [`NX_RAM_ADDR_W-1:0] wr_addr;
logic [`NX_RAM_DATA_W-1:0] wr_data;

// Loader to core
logic [NX_COUNT_W-1:0]     populated;

// Core to RAM and back
logic [`NX_RAM_ADDR_W-1:0] instr_addr;
logic                      instr_rd_en;
logic [`NX_RAM_DATA_W-1:0] instr_rd_data;

// ==================================================
// Instances
// ==================================================

// Writes the program, gated by core idle
nx_instr_loader i_loader (
      .i_clk        ( i_clk        )
    , .i_arst_n     ( i_arst_n     )
    , .i_load_valid ( i_load_valid )
    , .i_load_data  ( i_load_data  )
    , .i_load_clear ( i_load_clear )
    , .i_idle       ( o_idle       )
    , .o_wr_en      ( wr_en        )
    , .o_wr_addr    ( wr_addr      )
    , .o_wr_data    ( wr_data      )
    , .o_populated  ( populated    )
);

// Program store, stall shared with the core
nx_instr_ram i_ram (
      .i_clk     ( i_clk         )
    , .i_arst_n  ( i_arst_n      )
    , .i_wr_en   ( wr_en         )
    , .i_wr_addr ( wr_addr       )
    , .i_wr_data ( wr_data       )
    , .i_rd_en   ( instr_rd_en   )
    , .i_rd_addr ( instr_addr    )
    , .i_stall   ( i_stall       )
    , .o_rd_data ( instr_rd_data )
);

// Evaluates the stored program
nx_node_core i_core (
      .i_clk           ( i_clk         )
    , .i_arst_n        ( i_arst_n      )
    , .i_inputs        ( i_inputs      )
    , .o_outputs       ( o_outputs     )
    , .i_populated     ( populated     )
    , .i_trigger       ( i_trigger     )
    , .o_idle          ( o_idle        )
    , .o_instr_addr    ( instr_addr    )
    , .o_instr_rd_en   ( instr_rd_en   )
    , .i_instr_rd_data ( instr_rd_data )
    , .i_instr_stall   ( i_stall       )
);

endmodule : nx_node

// File: verilog/nx_node_core.sv
// Logic node core
`include "nx_config.svh"

module nx_node_core
import nx_pkg::*;
(
      input  logic                      i_clk
    , input  logic                      i_arst_n
    // Simulated logic I/O
    , input  logic [`NX_INPUTS-1:0]     i_inputs
    , output logic [`NX_OUTPUTS-1:0]    o_outputs
    // Run control
    , input  logic [NX_COUNT_W-1:0]     i_populated
    , input  logic                      i_trigger
    , output logic                      o_idle
    // Instruction fetch
    , output logic [`NX_RAM_ADDR_W-1:0] o_instr_addr
    , output logic                      o_instr_rd_en
    , input  logic [`NX_RAM_DATA_W-1:0] i_instr_rd_data
    , input  logic                      i_instr_stall
);

// ==================================================
// Signals
// ==================================================

// Stage valid flags and the postponed trigger
logic fetch_q, delay_q, exec_q, held_q;
logic busy, trig_seen, start, advance;

// Fetch
logic [`NX_RAM_ADDR_W-1:0] pc_q;
logic [NX_COUNT_W-1:0]     pc_next;

// Execute
instruction_t              instr_q;
logic                      exec_run;
logic                      result;
logic [2:0]                table_index;
logic [`NX_REGISTERS-1:0]  working_q;
logic [`NX_OUTPUTS-1:0]    outputs_q;
logic [NX_OUT_IDX_W-1:0]   out_idx_q;

// Operand from inputs or working registers
function automatic logic pick_operand(
    input logic                     from_input,
    input logic [NX_IOR_W-1:0]      index,
    input logic [`NX_INPUTS-1:0]    inputs,
    input logic [`NX_REGISTERS-1:0] regs
);
    logic [NX_REG_IDX_W-1:0] reg_sel;
    // Registers only use the low index bits
    reg_sel = index[NX_REG_IDX_W-1:0];
    return from_input ? inputs[index] : regs[reg_sel];
endfunction

// ==================================================
// Run control
// ==================================================

// Any stage still holding an instruction
assign busy      = fetch_q || delay_q || exec_q;
assign trig_seen = i_trigger || held_q;

// New run only from an empty pipeline with a program present
assign start   = trig_seen && !busy && (i_populated != '0);
assign advance = !i_instr_stall;

// Held trigger keeps idle low between back-to-back runs
assign o_idle = !busy && !held_q;

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        held_q <= 1'b0;
    end else begin
        // Single slot, consumed or dropped once the pipeline drains
        held_q <= trig_seen && busy;
    end
end

// ==================================================
// Fetch and delay stages
// ==================================================

assign pc_next = {1'b0, pc_q} + 1'b1;

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        fetch_q <= 1'b0;
        delay_q <= 1'b0;
        exec_q  <= 1'b0;
        pc_q    <= '0;
    end else begin
        if (start) begin
            fetch_q <= 1'b1;
            pc_q    <= '0;
        end else if (fetch_q && advance) begin
            // Last address reached, or program shrunk by a clear
            fetch_q <= (pc_next < i_populated);
            pc_q    <= pc_next[`NX_RAM_ADDR_W-1:0];
        end
        // Whole pipeline freezes under stall
        if (advance) begin
            delay_q <= fetch_q;
            exec_q  <= delay_q;
        end
    end
end

// RAM gates its own read with the stall
assign o_instr_addr  = pc_q;
assign o_instr_rd_en = fetch_q;

// ==================================================
// Execute stage
// ==================================================

// Capture the word the RAM returned for the delay stage
always_ff @(posedge i_clk) begin
    if (delay_q && advance) begin
        instr_q <= instruction_t'(i_instr_rd_data[$bits(instruction_t)-1:0]);
    end
end

assign exec_run = exec_q && advance;

// A is the most significant table index bit
assign table_index = {
    pick_operand(instr_q.src_a_ip, instr_q.src_a, i_inputs, working_q),
    pick_operand(instr_q.src_b_ip, instr_q.src_b, i_inputs, working_q),
    pick_operand(instr_q.src_c_ip, instr_q.src_c, i_inputs, working_q)
};

assign result = instr_q.truth[table_index];

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        working_q <= '0;
        outputs_q <= '0;
        out_idx_q <= '0;
    end else begin
        // Output position restarts with every run
        if (start) begin
            out_idx_q <= '0;
        end
        if (exec_run) begin
            working_q[instr_q.tgt_reg] <= result;
            if (instr_q.gen_out) begin
                outputs_q[out_idx_q] <= result;
                out_idx_q            <= out_idx_q + 1'b1;
            end
        end
    end
end

assign o_outputs = outputs_q;

endmodule : nx_node_core

// File: verilog/nx_instr_ram.sv
// Instruction RAM
`include "nx_config.svh"

module nx_instr_ram
import nx_pkg::*;
(
      input  logic                      i_clk
    , input  logic                      i_arst_n
    // Write port from the loader
    , input  logic                      i_wr_en
    , input  logic [`NX_RAM_ADDR_W-1:0] i_wr_addr
    , input  logic [`NX_RAM_DATA_W-1:0] i_wr_data
    // Read port to the core
    , input  logic                      i_rd_en
    , input  logic [`NX_RAM_ADDR_W-1:0] i_rd_addr
    , input  logic                      i_stall
    , output logic [`NX_RAM_DATA_W-1:0] o_rd_data
);

// ==================================================
// Storage
// ==================================================

// One word per instruction slot
logic [`NX_RAM_DATA_W-1:0] mem [NX_RAM_DEPTH];

// Write lands on the enabled edge
always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
        mem[i_wr_addr] <= i_wr_data;
    end
end

// ==================================================
// Registered read
// ==================================================

// One cycle latency
// Stall freezes the output so the core can pick it up later
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_rd_data <= '0;
    end else if (i_rd_en && !i_stall) begin
        o_rd_data <= mem[i_rd_addr];
    end
end

endmodule : nx_instr_ram

// File: verilog/nx_instr_loader.sv
// Instruction loader
`include "nx_config.svh"

module nx_instr_loader
import nx_pkg::*;
(
      input  logic                      i_clk
    , input  logic                      i_arst_n
    // Host instruction stream
    , input  logic                      i_load_valid
    , input  logic [`NX_RAM_DATA_W-1:0] i_load_data
    , input  logic                      i_load_clear
    // Core activity
    , input  logic                      i_idle
    // RAM write port
    , output logic                      o_wr_en
    , output logic [`NX_RAM_ADDR_W-1:0] o_wr_addr
    , output logic [`NX_RAM_DATA_W-1:0] o_wr_data
    // Stored program length
    , output logic [NX_COUNT_W-1:0]     o_populated
);

// ==================================================
// State
// ==================================================

// Count doubles as the next free address
logic [NX_COUNT_W-1:0] count_q;
logic                  full;
logic                  accept;

// ==================================================
// Load acceptance
// ==================================================

// RAM holds a complete program
assign full = (count_q == NX_COUNT_W'(NX_RAM_DEPTH));

// Only take words while the core sits idle
// Clear wins over a load in the same cycle
assign accept = i_load_valid && i_idle && !full && !i_load_clear;

// ==================================================
// Pointer and write strobe
// ==================================================

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        count_q <= '0;
        o_wr_en <= 1'b0;
    end else begin
        // One-cycle write per accepted word
        o_wr_en <= accept;
        if (i_load_clear) begin
            // Rewind to address zero
            count_q <= '0;
        end else if (accept) begin
            count_q <= count_q + 1'b1;
        end
    end
end

// Registered address and data, qualified by o_wr_en
always_ff @(posedge i_clk) begin
    if (accept) begin
        o_wr_addr <= count_q[`NX_RAM_ADDR_W-1:0];
        o_wr_data <= i_load_data;
    end
end

assign o_populated = count_q;

endmodule : nx_instr_loader

// File: verilog/nx_pkg.sv
// Logic node shared types
`include "nx_config.svh"

package nx_pkg;

    // ==================================================
    // Derived widths
    // ==================================================

    // Operand index, wide enough to reach any input
    localparam int unsigned NX_IOR_W     = $clog2(`NX_INPUTS);

    // Working register select
    localparam int unsigned NX_REG_IDX_W = $clog2(`NX_REGISTERS);

    // Position within the output vector
    localparam int unsigned NX_OUT_IDX_W = $clog2(`NX_OUTPUTS);

    // Instruction slots in the RAM
    localparam int unsigned NX_RAM_DEPTH = 1 << `NX_RAM_ADDR_W;

    // Program length, one extra bit so a full RAM is countable
    localparam int unsigned NX_COUNT_W   = `NX_RAM_ADDR_W + 1;

    // ==================================================
    // Instruction format
    // ==================================================

    // 31 bits, most significant field first
    typedef struct packed {
        // Result for each {A, B, C} combination
        logic [7:0]              truth;
        // Operand A, flag set picks an input
        logic                    src_a_ip;
        logic [NX_IOR_W-1:0]     src_a;
        // Operand B
        logic                    src_b_ip;
        logic [NX_IOR_W-1:0]     src_b;
        // Operand C
        logic                    src_c_ip;
        logic [NX_IOR_W-1:0]     src_c;
        // Destination working register
        logic [NX_REG_IDX_W-1:0] tgt_reg;
        // Also append result to outputs
        logic                    gen_out;
    } instruction_t;

endpackage : nx_pkg

// File: include/nx_config.svh
// Logic node configuration
`ifndef NX_CONFIG_SVH
`define NX_CONFIG_SVH

// ==================================================
// Simulated logic I/O
// ==================================================

// External input bits sampled by the node
`define NX_INPUTS     32

// Bits in the generated output vector
`define NX_OUTPUTS    32

// Working registers, kept across runs
`define NX_REGISTERS  16

// ==================================================
// Instruction memory geometry
// ==================================================

// Address bits, 1024 instruction slots
`define NX_RAM_ADDR_W 10

// Stored word width, instruction sits in the low bits
`define NX_RAM_DATA_W 32

`endif
